// ==== speech_pkg.sv ====
////////////////////
// Widths, register map, sample and frame types of the speech synthesizer
////////////////////
package speech_pkg;

   localparam int NSTAGES    = 4;
   localparam int SAMPLE_DIV = 20;   // Clocks per sample tick
   localparam int SAMPLE_W   = 14;
   localparam int COEF_W     = 10;
   localparam int COEF_FRAC  = 9;
   localparam int OUT_W      = 10;   // Top bits of the sample
   localparam int DATA_W     = 10;
   localparam int ADDR_W     = 3;
   localparam int LFSR_W     = 13;

   // Product and sum widths inside a lattice stage
   localparam int PROD_W = SAMPLE_W + COEF_W;
   localparam int SUM_W  = PROD_W + 1;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;

   localparam addr_t REG_ENERGY = 3'd0;
   localparam addr_t REG_PITCH  = 3'd1;
   localparam addr_t REG_K0     = 3'd2;   // k0..k3 at 2..5
   localparam addr_t REG_CMD    = 3'd6;
   localparam addr_t REG_STATUS = 3'd7;

   localparam logic [LFSR_W-1:0] LFSR_SEED = '1;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [COEF_W-1:0]   coef_t;
   typedef logic [7:0]                 energy_t;
   typedef logic [7:0]                 pitch_t;   // 0 is unvoiced
   typedef logic signed [OUT_W-1:0]    out_t;

   // Active frame
   typedef struct packed {
      energy_t                  energy;
      pitch_t                   pitch;
      coef_t [NSTAGES-1:0]      k;
   } frame_t;

endpackage

// ==== lattice_link_if.sv ====
////////////////////
// Link between neighbouring lattice filter stages
////////////////////
`timescale 1ns/10ps

interface lattice_link_if;

   speech_pkg::sample_t fwd;     // Forward path, from upstream
   speech_pkg::sample_t bwd;     // Backward path, from downstream
   logic                tick;
   logic                clear;

   modport up (
      output fwd, tick, clear,
      input  bwd
   );

   modport down (
      input  fwd, tick, clear,
      output bwd
   );

endinterface

// ==== host_regs.sv ====
////////////////////
// Host register bus, shadow frame registers and frame commit at the tick
////////////////////
`timescale 1ns/10ps

module host_regs (
   input  logic                clk,
   input  logic                reset,
   input  logic                ws,
   input  logic                rs,
   input  speech_pkg::addr_t   addr,
   input  speech_pkg::data_t   dd,
   input  logic                tick,
   output speech_pkg::data_t   dq,
   output logic                rdy,
   output speech_pkg::frame_t  frame,
   output logic                talking,
   output logic                restart
);

   speech_pkg::frame_t shadow;
   speech_pkg::data_t  rd_data;
   speech_pkg::addr_t  k_idx;
   logic               k_sel;
   logic               req_pend;    // Start or stop waiting for a tick
   logic               req_start;

   // Addresses below REG_K0 wrap to large indices
   assign k_idx = addr - speech_pkg::REG_K0;
   assign k_sel = (k_idx < speech_pkg::addr_t'(speech_pkg::NSTAGES));

   assign restart = tick & req_pend;

   always_comb begin
      rd_data = '0;
      if (addr == speech_pkg::REG_ENERGY)
         rd_data = speech_pkg::data_t'(shadow.energy);
      else if (addr == speech_pkg::REG_PITCH)
         rd_data = speech_pkg::data_t'(shadow.pitch);
      else if (k_sel)
         rd_data = speech_pkg::data_t'(shadow.k[k_idx]);   // Sign extends
      else if (addr == speech_pkg::REG_STATUS)
         rd_data = speech_pkg::data_t'(talking);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         shadow    <= '0;
         rdy       <= 1'b0;
         talking   <= 1'b0;
         req_pend  <= 1'b0;
         req_start <= 1'b0;
      end else begin
         rdy <= ws | rs;
         if (ws) begin
            if (addr == speech_pkg::REG_ENERGY)
               shadow.energy <= speech_pkg::energy_t'(dd);
            else if (addr == speech_pkg::REG_PITCH)
               shadow.pitch <= speech_pkg::pitch_t'(dd);
            else if (k_sel)
               shadow.k[k_idx] <= speech_pkg::coef_t'(dd);
         end
         if (restart) begin
            talking  <= req_start;
            req_pend <= 1'b0;
         end
         if (ws && addr == speech_pkg::REG_CMD) begin   // Taken at the next tick
            req_pend  <= 1'b1;
            req_start <= dd[0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rs)
         dq <= rd_data;
      if (restart && req_start)
         frame <= shadow;
   end

endmodule

// ==== excitation_gen.sv ====
////////////////////
// Sample tick divider, pitch pulse counter and noise LFSR
////////////////////
`timescale 1ns/10ps

module excitation_gen (
   input  logic                clk,
   input  logic                reset,
   input  speech_pkg::frame_t  frame,
   input  logic                talking,
   input  logic                restart,
   output logic                tick,
   lattice_link_if.up          link
);

   typedef logic [$clog2(speech_pkg::SAMPLE_DIV)-1:0] div_t;

   div_t                           div_cnt;
   speech_pkg::pitch_t             pulse_cnt;
   logic [speech_pkg::LFSR_W-1:0]  lfsr;
   speech_pkg::sample_t            amp;
   speech_pkg::sample_t            exc;

   assign tick = (div_cnt == div_t'(speech_pkg::SAMPLE_DIV - 1));
   assign amp  = speech_pkg::sample_t'({frame.energy, 4'b0000});   // Energy times 16

   always_comb begin
      if (!talking)
         exc = '0;
      else if (frame.pitch == '0)
         exc = lfsr[0] ? amp : -amp;   // Unvoiced noise
      else if (pulse_cnt == '0)
         exc = amp;
      else
         exc = '0;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         div_cnt   <= '0;
         pulse_cnt <= '0;
         lfsr      <= speech_pkg::LFSR_SEED;
      end else begin
         div_cnt <= tick ? '0 : div_cnt + 1'b1;
         if (tick) begin
            if (talking)   // Same taps as the 13 bit noise source of the chip
               lfsr <= {lfsr[0], lfsr[12:4], lfsr[3] ^ lfsr[12],
                        lfsr[2] ^ lfsr[12], lfsr[1] ^ lfsr[0]};
            if (restart)
               pulse_cnt <= '0;
            else if (talking && frame.pitch != '0)
               pulse_cnt <= (pulse_cnt == '0) ? frame.pitch - 1'b1 : pulse_cnt - 1'b1;
         end
      end
   end

   assign link.fwd   = exc;
   assign link.tick  = tick;
   assign link.clear = restart;

endmodule

// ==== lattice_stage.sv ====
////////////////////
// One reflection stage of the all-pole lattice filter
////////////////////
`timescale 1ns/10ps

module lattice_stage (
   input  logic                clk,
   input  logic                reset,
   input  speech_pkg::coef_t   k,
   lattice_link_if.down        up,
   lattice_link_if.up          dn
);

   speech_pkg::sample_t                 b;        // Backward delay
   speech_pkg::sample_t                 f_out;
   speech_pkg::sample_t                 b_next;
   logic signed [speech_pkg::PROD_W-1:0] kb_prod;
   logic signed [speech_pkg::PROD_W-1:0] kf_prod;
   logic signed [speech_pkg::SUM_W-1:0]  f_sum;
   logic signed [speech_pkg::SUM_W-1:0]  b_sum;

   function automatic speech_pkg::sample_t saturate(
      input logic signed [speech_pkg::SUM_W-1:0] v);
      localparam int W = speech_pkg::SAMPLE_W;
      localparam int S = speech_pkg::SUM_W;
      if (v[S-1:W-1] == {(S-W+1){v[S-1]}})
         return v[W-1:0];
      else if (v[S-1])
         return {1'b1, {(W-1){1'b0}}};
      else
         return {1'b0, {(W-1){1'b1}}};
   endfunction

   always_comb begin
      kb_prod = k * b;
      f_sum   = up.fwd - (kb_prod >>> speech_pkg::COEF_FRAC);
      f_out   = saturate(f_sum);
      kf_prod = k * f_out;
      b_sum   = dn.bwd + (kf_prod >>> speech_pkg::COEF_FRAC);
      b_next  = saturate(b_sum);
   end

   always_ff @(posedge clk) begin
      if (reset)
         b <= '0;
      else if (up.tick)
         b <= up.clear ? '0 : b_next;
   end

   assign up.bwd   = b;
   assign dn.fwd   = f_out;
   assign dn.tick  = up.tick;
   assign dn.clear = up.clear;

endmodule

// ==== sample_out.sv ====
////////////////////
// Output sample register and valid strobe
////////////////////
`timescale 1ns/10ps

module sample_out (
   input  logic                clk,
   input  logic                reset,
   input  logic                talking,
   lattice_link_if.down        link,
   output speech_pkg::out_t    dac_out,
   output logic                sample_valid
);

   logic take;

   assign take     = link.tick & talking;
   assign link.bwd = '0;   // End of the backward chain

   always_ff @(posedge clk) begin
      if (reset)
         sample_valid <= 1'b0;
      else
         sample_valid <= take;
   end

   // Top bits only, low bits dropped
   always_ff @(posedge clk) begin
      if (take)
         dac_out <= link.fwd[speech_pkg::SAMPLE_W-1 -: speech_pkg::OUT_W];
   end

endmodule

// ==== speech_synth.sv ====
////////////////////
// Speech synthesizer top: host registers, excitation, lattice and output
////////////////////
`timescale 1ns/10ps

module speech_synth (
   input  logic               clk,
   input  logic               reset,
   input  logic               ws,
   input  logic               rs,
   input  speech_pkg::addr_t  addr,
   input  speech_pkg::data_t  dd,
   output speech_pkg::data_t  dq,
   output logic               rdy,
   output speech_pkg::out_t   dac_out,
   output logic               sample_valid
);

   speech_pkg::frame_t frame;
   logic               talking;
   logic               restart;
   logic               tick;

   lattice_link_if link [speech_pkg::NSTAGES+1] ();

   host_regs u_host_regs (
      .clk     (clk),
      .reset   (reset),
      .ws      (ws),
      .rs      (rs),
      .addr    (addr),
      .dd      (dd),
      .tick    (tick),
      .dq      (dq),
      .rdy     (rdy),
      .frame   (frame),
      .talking (talking),
      .restart (restart)
   );

   excitation_gen u_excitation_gen (
      .clk     (clk),
      .reset   (reset),
      .frame   (frame),
      .talking (talking),
      .restart (restart),
      .tick    (tick),
      .link    (link[0])
   );

   for (genvar gi = 0; gi < speech_pkg::NSTAGES; gi++) begin : g_stage
      lattice_stage u_stage (
         .clk   (clk),
         .reset (reset),
         .k     (frame.k[gi]),
         .up    (link[gi]),
         .dn    (link[gi+1])
      );
   end

   sample_out u_sample_out (
      .clk          (clk),
      .reset        (reset),
      .talking      (talking),
      .link         (link[speech_pkg::NSTAGES]),
      .dac_out      (dac_out),
      .sample_valid (sample_valid)
   );

endmodule

// ==== speech_synth_asserts.sv ====
////////////////////
// Bound checks on host ready, sample valid and talking timing
////////////////////
`timescale 1ns/10ps

module speech_synth_asserts (
   input logic clk,
   input logic reset,
   input logic ws,
   input logic rs,
   input logic rdy,
   input logic tick,
   input logic talking,
   input logic sample_valid
);

   // Ready exactly one cycle after any strobe
   assert property (@(posedge clk) disable iff (reset) rdy == $past(ws | rs))
      else $error("rdy does not follow a strobe by exactly one cycle");

   assert property (@(posedge clk) disable iff (reset) sample_valid |=> !sample_valid)
      else $error("sample_valid high on two consecutive cycles");

   assert property (@(posedge clk) disable iff (reset)
                    (talking != $past(talking)) |-> $past(tick))
      else $error("talking changed outside the cycle after a tick");

endmodule

bind speech_synth speech_synth_asserts u_asserts (
   .clk          (clk),
   .reset        (reset),
   .ws           (ws),
   .rs           (rs),
   .rdy          (rdy),
   .tick         (tick),
   .talking      (talking),
   .sample_valid (sample_valid)
);

// ==== tb_speech_synth.sv ====
////////////////////
// Clock, reset, host bus tasks, reference model and checks of the synthesizer
////////////////////
`timescale 1ns/10ps

module tb_speech_synth;

   localparam int CLK_PERIOD  = 8;
   localparam int REQ_SAMPLES = 60 + 20 + 40 + 10 + 30 + 40;   // Samples the tests wait for
   localparam int WATCHDOG_NS = REQ_SAMPLES * speech_pkg::SAMPLE_DIV * CLK_PERIOD * 12 / 10;

   logic               clk;
   logic               reset;
   logic               ws;
   logic               rs;
   speech_pkg::addr_t  addr;
   speech_pkg::data_t  dd;
   speech_pkg::data_t  dq;
   logic               rdy;
   speech_pkg::out_t   dac_out;
   logic               sample_valid;

   // Reference model state
   int                             m_div;
   bit                             m_talking;
   bit                             m_pend;
   bit                             m_start;
   speech_pkg::data_t              shadow [6];
   int                             act_energy;
   int                             act_pitch;
   int                             act_k [speech_pkg::NSTAGES];
   logic [speech_pkg::LFSR_W-1:0]  lfsr_m;
   int                             pulse_m;
   int                             b_m [speech_pkg::NSTAGES];
   speech_pkg::data_t              exp_rd;
   speech_pkg::out_t               exp_q [$];

   logic [31:0]        rng;
   speech_pkg::coef_t  k_next [speech_pkg::NSTAGES];
   int                 n_checked;
   speech_pkg::data_t  rd;

   speech_synth UUT (
      .clk          (clk),
      .reset        (reset),
      .ws           (ws),
      .rs           (rs),
      .addr         (addr),
      .dd           (dd),
      .dq           (dq),
      .rdy          (rdy),
      .dac_out      (dac_out),
      .sample_valid (sample_valid)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic int clip(input int v);
      int lim;
      lim = 1 << (speech_pkg::SAMPLE_W - 1);
      if (v > lim - 1)
         return lim - 1;
      else if (v < -lim)
         return -lim;
      else
         return v;
   endfunction

   // Advances the model by one sample of excitation through the lattice
   function automatic speech_pkg::out_t next_sample();
      int amp;
      int f;
      int fo [speech_pkg::NSTAGES];
      amp = act_energy * 16;
      if (act_pitch == 0)
         f = lfsr_m[0] ? amp : -amp;
      else
         f = (pulse_m == 0) ? amp : 0;
      lfsr_m = {lfsr_m[0], lfsr_m[12:1]} ^ {10'b0, lfsr_m[12], lfsr_m[12], lfsr_m[0]};
      if (act_pitch != 0)
         pulse_m = (pulse_m == 0) ? act_pitch - 1 : pulse_m - 1;
      for (int i = 0; i < speech_pkg::NSTAGES; i++) begin
         f = clip(f - ((act_k[i] * b_m[i]) >>> speech_pkg::COEF_FRAC));
         fo[i] = f;
      end
      // Ascending order keeps the old b of the next stage
      for (int i = 0; i < speech_pkg::NSTAGES; i++)
         b_m[i] = clip(((i == speech_pkg::NSTAGES - 1) ? 0 : b_m[i+1])
                       + ((act_k[i] * fo[i]) >>> speech_pkg::COEF_FRAC));
      return speech_pkg::out_t'(f >>> (speech_pkg::SAMPLE_W - speech_pkg::OUT_W));
   endfunction

   always @(posedge clk) begin
      if (reset) begin
         m_div = 0;
         m_talking = 1'b0;
         m_pend = 1'b0;
         m_start = 1'b0;
         lfsr_m = speech_pkg::LFSR_SEED;
         pulse_m = 0;
         foreach (shadow[i]) shadow[i] = '0;
         foreach (b_m[i]) b_m[i] = 0;
      end else begin
         if (rs)
            exp_rd = (addr < 6) ? shadow[addr] : speech_pkg::data_t'(m_talking && addr == 7);
         if (m_div == speech_pkg::SAMPLE_DIV - 1) begin
            if (m_talking)
               exp_q.push_back(next_sample());
            if (m_pend) begin   // Frame commit
               if (m_start) begin
                  act_energy = int'(shadow[0]);
                  act_pitch = int'(shadow[1]);
                  foreach (act_k[i]) act_k[i] = int'(speech_pkg::coef_t'(shadow[2+i]));
               end
               foreach (b_m[i]) b_m[i] = 0;
               pulse_m = 0;
               m_talking = m_start;
               m_pend = 1'b0;
            end
            m_div = 0;
         end else begin
            m_div++;
         end
         if (ws && addr < 2)
            shadow[addr] = {2'b00, dd[7:0]};
         else if (ws && addr < 6)
            shadow[addr] = dd;
         else if (ws && addr == speech_pkg::REG_CMD) begin
            m_pend = 1'b1;
            m_start = dd[0];
         end
      end
   end

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_sample(input speech_pkg::out_t got, input speech_pkg::out_t exp);
      if (got !== exp) begin
         $display("[ERROR] at %0d ns: sample %0d is %0d, expected %0d",
                  $time, n_checked, got, exp);
         abort_run();
      end
   endtask

   task automatic check_data(input speech_pkg::data_t got, input speech_pkg::data_t exp,
                             input speech_pkg::addr_t a);
      if (got !== exp) begin
         $display("[ERROR] at %0d ns: read of address %0d gave %h, expected %h",
                  $time, a, got, exp);
         abort_run();
      end
   endtask

   always @(negedge clk) begin
      if (!reset && sample_valid) begin
         if (exp_q.size() == 0) begin
            $display("[ERROR] at %0d ns: sample_valid with no sample expected", $time);
            abort_run();
         end else begin
            check_sample(dac_out, exp_q.pop_front());
            n_checked++;
         end
      end
   end

   task automatic wait_rdy(input speech_pkg::addr_t a);
      int n;
      n = 0;
      while (!rdy && n < 4) begin
         @(negedge clk);
         n++;
      end
      if (!rdy) begin
         $display("No rdy after the strobe to address %0d", a);
         abort_run();
      end
   endtask

   task automatic write_reg(input speech_pkg::addr_t a, input speech_pkg::data_t d);
      @(negedge clk);
      ws = 1'b1;
      addr = a;
      dd = d;
      @(negedge clk);
      ws = 1'b0;
      wait_rdy(a);
   endtask

   task automatic read_reg(input speech_pkg::addr_t a, output speech_pkg::data_t val);
      @(negedge clk);
      rs = 1'b1;
      addr = a;
      @(negedge clk);
      rs = 1'b0;
      wait_rdy(a);
      val = dq;
      check_data(dq, exp_rd, a);
   endtask

   task automatic write_frame(input speech_pkg::energy_t e, input speech_pkg::pitch_t p);
      write_reg(speech_pkg::REG_ENERGY, speech_pkg::data_t'(e));
      write_reg(speech_pkg::REG_PITCH, speech_pkg::data_t'(p));
      for (int i = 0; i < speech_pkg::NSTAGES; i++)
         write_reg(speech_pkg::addr_t'(speech_pkg::REG_K0 + i), speech_pkg::data_t'(k_next[i]));
   endtask

   task automatic fill_random_k();
      for (int i = 0; i < speech_pkg::NSTAGES; i++)
         k_next[i] = speech_pkg::coef_t'(int'(next_rand() % 32'd767) - 383);   // Below 0.75
   endtask

   function automatic speech_pkg::energy_t rand_energy();
      return speech_pkg::energy_t'(next_rand() % 32'd255 + 32'd1);
   endfunction

   task automatic wait_samples(input int n);
      int target;
      target = n_checked + n;
      while (n_checked < target)
         @(negedge clk);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      abort_run();
   end

   initial begin
      reset = 1'b1;
      ws = 1'b0;
      rs = 1'b0;
      addr = '0;
      dd = '0;
      rng = 32'hcf18_f4d3;
      n_checked = 0;
      repeat (4) @(negedge clk);
      reset = 1'b0;

      for (int a = 0; a < 6; a++) begin
         read_reg(speech_pkg::addr_t'(a), rd);
         check_data(rd, '0, speech_pkg::addr_t'(a));
      end
      read_reg(speech_pkg::REG_STATUS, rd);
      check_data(rd, '0, speech_pkg::REG_STATUS);
      repeat (100) @(negedge clk);

      // Register readback while silent
      for (int a = 0; a < 6; a++)
         write_reg(speech_pkg::addr_t'(a), speech_pkg::data_t'(next_rand()));
      for (int a = 0; a < 6; a++)
         read_reg(speech_pkg::addr_t'(a), rd);
      read_reg(speech_pkg::REG_STATUS, rd);
      check_data(rd, '0, speech_pkg::REG_STATUS);

      fill_random_k();
      write_frame(rand_energy(), 8'd7);
      write_reg(speech_pkg::REG_CMD, 10'd1);
      wait_samples(60);

      foreach (k_next[i]) k_next[i] = '0;
      write_frame(rand_energy(), 8'd0);
      write_reg(speech_pkg::REG_CMD, 10'd1);
      wait_samples(20);
      fill_random_k();
      write_frame(rand_energy(), 8'd0);   // Noise through the filter
      write_reg(speech_pkg::REG_CMD, 10'd1);
      wait_samples(40);

      // New frame while talking takes effect at the next command
      fill_random_k();
      write_frame(rand_energy(), 8'd5);
      wait_samples(10);
      write_reg(speech_pkg::REG_CMD, 10'd1);
      wait_samples(30);

      foreach (k_next[i]) k_next[i] = speech_pkg::coef_t'((i % 2 == 0) ? 383 : -383);
      write_frame(8'd255, 8'd0);
      write_reg(speech_pkg::REG_CMD, 10'd1);
      wait_samples(40);
      write_reg(speech_pkg::REG_CMD, 10'd0);
      repeat (3 * speech_pkg::SAMPLE_DIV) @(negedge clk);
      read_reg(speech_pkg::REG_STATUS, rd);
      check_data(rd, '0, speech_pkg::REG_STATUS);

      if (exp_q.size() == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("%0d expected samples never appeared", exp_q.size());
         $display("tests failed");
         $fatal(1, "Missing samples at the end of the run");
      end
   end

endmodule

// ==== src.f ====
speech_pkg.sv
lattice_link_if.sv
host_regs.sv
excitation_gen.sv
lattice_stage.sv
sample_out.sv
speech_synth.sv
speech_synth_asserts.sv
tb_speech_synth.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the speech synthesizer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_speech_synth -f src.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
if ! grep -q "all tests passed" sim.log; then
   echo "Simulation ended without a pass result"
   exit 1
fi
echo "Simulation finished cleanly"
